// ==== logic/smc_defs.svh ====
// Width defines for the address, data and wait-state counter
`ifndef SMC_DEFS_SVH
`define SMC_DEFS_SVH

//--------------------------------------------------
// Memory interface widths
//--------------------------------------------------
`define SMC_ADDR_W 16 // Address bus
`define SMC_DATA_W 16 // Data bus, read and write

//--------------------------------------------------
// Timing counter widths
//--------------------------------------------------
// Wait-state count, so up to 255 extra strobe cycles
`define SMC_WS_W 8

`endif

// ==== logic/smc_pkg.sv ====
// Controller state enumeration
package smc_pkg;

  //--------------------------------------------------
  // Access phases of the static memory controller
  //--------------------------------------------------
  // One access walks IDLE, STORE, LE, RW, FLOAT
  // LE and FLOAT are skipped when their count is zero
  typedef enum logic [2:0]
  {
    IDLE  = 3'd0, // Waiting for a request
    STORE = 3'd1, // Request latched
    LE    = 3'd2, // Chip select leading edge
    RW    = 3'd3, // Read or write strobe with wait states
    FLOAT = 3'd4  // Chip select trailing edge
  } smc_state_t;

endpackage

// ==== logic/smc_state.sv ====
// Controller FSM with phase enables, load, read latch and done decode
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_state
(
  input  logic                  sys_clk27,     // System clock
  input  logic                  n_sys_reset27, // Async reset, active low
  input  logic                  req,           // One-cycle access strobe
  input  logic [1:0]            csle_count,    // Leading-edge count
  input  logic [`SMC_WS_W-1:0]  ws_count,      // Wait-state count
  input  logic [1:0]            cste_count,    // Trailing-edge count
  input  logic                  req_write_q,   // Stored direction, high for write
  output smc_pkg::smc_state_t   current_state, // Registered state
  output logic                  load,          // Take request and configuration
  output logic                  le_enable,     // Leading-edge counter decrement
  output logic                  ws_enable,     // Wait-state counter decrement
  output logic                  cste_enable,   // Trailing-edge counter decrement
  output logic                  latch_data,    // Capture read data this edge
  output logic                  smc_done       // Last cycle of the access
);

  import smc_pkg::*;

  smc_state_t next_state; // Combinational next state

  //--------------------------------------------------
  // Request acceptance
  //--------------------------------------------------
  // Strobes outside IDLE are simply dropped
  assign load = (current_state == IDLE) && req;

  //--------------------------------------------------
  // Next-state logic
  //--------------------------------------------------
  always_comb
  begin
    case (current_state)
      IDLE:
        if (req)
          next_state = STORE;
        else
          next_state = IDLE;

      STORE: // Skip LE when no leading edge was asked for
        if (csle_count != 2'd0)
          next_state = LE;
        else
          next_state = RW;

      LE: // Count 1 marks the last LE cycle
        if (csle_count <= 2'd1)
          next_state = RW;
        else
          next_state = LE;

      RW:
      begin
        if (ws_count != '0)
          next_state = RW; // Still counting wait states
        else if (cste_count != 2'd0)
          next_state = FLOAT;
        else
          next_state = IDLE;
      end

      FLOAT: // Same shape as LE
        if (cste_count <= 2'd1)
          next_state = IDLE;
        else
          next_state = FLOAT;

      default:
        next_state = IDLE; // Recover from unused codes
    endcase
  end

  //--------------------------------------------------
  // State register
  //--------------------------------------------------
  always_ff @(posedge sys_clk27 or negedge n_sys_reset27)
  begin
    if (!n_sys_reset27)
      current_state <= IDLE;
    else
      current_state <= next_state;
  end

  //--------------------------------------------------
  // Counter enables
  //--------------------------------------------------
  // Each counter only moves inside its own phase
  assign le_enable   = (current_state == LE);
  // No decrement on the exit cycle, count already at zero
  assign ws_enable   = (current_state == RW) && (next_state == RW);
  assign cste_enable = (current_state == FLOAT);

  //--------------------------------------------------
  // Read latch and done decode
  //--------------------------------------------------
  // Final RW cycle of a read, data settled on the bus
  assign latch_data = (current_state == RW) && (ws_count == '0) && !req_write_q;

  // Leaving RW or FLOAT for IDLE ends the access
  assign smc_done = ((current_state == RW) || (current_state == FLOAT)) &&
                    (next_state == IDLE);

endmodule

// ==== logic/smc_timing_counters.sv ====
// Leading-edge, wait-state and trailing-edge down-counters
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_timing_counters
(
  input  logic                  sys_clk27,     // System clock
  input  logic                  n_sys_reset27, // Async reset, active low
  input  logic                  load,          // Request accepted
  input  logic                  le_enable,     // Decrement leading edge
  input  logic                  ws_enable,     // Decrement wait states
  input  logic                  cste_enable,   // Decrement trailing edge
  input  logic [1:0]            cfg_csle,      // Leading-edge cycles
  input  logic [`SMC_WS_W-1:0]  cfg_ws,        // Wait states
  input  logic [1:0]            cfg_cste,      // Trailing-edge cycles
  output logic [1:0]            csle_count,
  output logic [`SMC_WS_W-1:0]  ws_count,
  output logic [1:0]            cste_count
);

  //--------------------------------------------------
  // Chip select leading edge
  //--------------------------------------------------
  always_ff @(posedge sys_clk27 or negedge n_sys_reset27)
  begin
    if (!n_sys_reset27)
      csle_count <= 2'd0;
    else if (load)
      csle_count <= cfg_csle; // Sampled only at acceptance
    else if (le_enable && (csle_count != 2'd0))
      csle_count <= csle_count - 2'd1;
  end

  //--------------------------------------------------
  // Wait states
  //--------------------------------------------------
  // Strobe phase lasts one cycle more than this count
  always_ff @(posedge sys_clk27 or negedge n_sys_reset27)
  begin
    if (!n_sys_reset27)
      ws_count <= '0;
    else if (load)
      ws_count <= cfg_ws;
    else if (ws_enable && (ws_count != '0))
      ws_count <= ws_count - 1'b1; // Floor at zero
  end

  //--------------------------------------------------
  // Chip select trailing edge
  //--------------------------------------------------
  always_ff @(posedge sys_clk27 or negedge n_sys_reset27)
  begin
    if (!n_sys_reset27)
      cste_count <= 2'd0;
    else if (load)
      cste_count <= cfg_cste; // Held through LE and RW
    else if (cste_enable && (cste_count != 2'd0))
      cste_count <= cste_count - 2'd1;
  end

endmodule

// ==== logic/smc_mem_pins.sv ====
// Memory pin block with address and data hold, strobes, read capture and done
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_mem_pins
(
  input  logic                    sys_clk27,     // System clock
  input  logic                    n_sys_reset27, // Async reset, active low
  input  logic                    load,          // Request accepted
  input  smc_pkg::smc_state_t     current_state, // FSM state
  input  logic                    latch_data,    // Capture read data
  input  logic                    smc_done,      // Last cycle of access
  input  logic                    req_write,     // Host direction
  input  logic [`SMC_ADDR_W-1:0]  req_addr,
  input  logic [`SMC_DATA_W-1:0]  req_wdata,
  input  logic [`SMC_DATA_W-1:0]  mem_rdata,
  output logic                    req_write_q,   // Stored direction
  output logic [`SMC_ADDR_W-1:0]  mem_addr,
  output logic [`SMC_DATA_W-1:0]  mem_wdata,
  output logic                    mem_cs_n,
  output logic                    mem_oe_n,
  output logic                    mem_we_n,
  output logic [`SMC_DATA_W-1:0]  rdata,         // Held until next done
  output logic                    done           // One-cycle completion
);

  import smc_pkg::*;

  //--------------------------------------------------
  // Request hold
  //--------------------------------------------------
  always_ff @(posedge sys_clk27)
  begin
    if (load)
    begin
      mem_addr  <= req_addr;  // Stable for the whole access
      mem_wdata <= req_wdata;
    end
  end

  always_ff @(posedge sys_clk27 or negedge n_sys_reset27)
  begin
    if (!n_sys_reset27)
      req_write_q <= 1'b0;
    else if (load)
      req_write_q <= req_write;
  end

  //--------------------------------------------------
  // Memory strobes
  //--------------------------------------------------
  // Chip select flop, falls leaving STORE, rises after the last cycle
  always_ff @(posedge sys_clk27 or negedge n_sys_reset27)
  begin
    if (!n_sys_reset27)
      mem_cs_n <= 1'b1;
    else if (smc_done)
      mem_cs_n <= 1'b1;
    else if (current_state == STORE)
      mem_cs_n <= 1'b0;
  end

  // Strobes decoded from the state and direction flops only
  assign mem_oe_n = !((current_state == RW) && !req_write_q);
  assign mem_we_n = !((current_state == RW) && req_write_q);

  //--------------------------------------------------
  // Read capture and done
  //--------------------------------------------------
  always_ff @(posedge sys_clk27 or negedge n_sys_reset27)
  begin
    if (!n_sys_reset27)
    begin
      rdata <= '0;
      done  <= 1'b0;
    end
    else
    begin
      if (latch_data)
        rdata <= mem_rdata; // Last RW edge of a read
      done <= smc_done;     // Lands in first IDLE cycle
    end
  end

endmodule

// ==== logic/smc_lite.sv ====
// Static memory controller top level with FSM, counters and pin block
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_lite
(
  input  logic                    sys_clk27,     // System clock
  input  logic                    n_sys_reset27, // Async reset, active low
  input  logic                    req,           // Start strobe, legal in idle
  input  logic                    req_write,     // High for write
  input  logic [`SMC_ADDR_W-1:0]  req_addr,
  input  logic [`SMC_DATA_W-1:0]  req_wdata,
  input  logic [1:0]              cfg_csle,      // Leading-edge cycles 0-3
  input  logic [`SMC_WS_W-1:0]    cfg_ws,        // Wait states 0-255
  input  logic [1:0]              cfg_cste,      // Trailing-edge cycles 0-3
  output logic                    done,
  output logic [`SMC_DATA_W-1:0]  rdata,
  output logic                    idle,
  output logic [`SMC_ADDR_W-1:0]  mem_addr,
  output logic [`SMC_DATA_W-1:0]  mem_wdata,
  output logic                    mem_cs_n,
  output logic                    mem_oe_n,
  output logic                    mem_we_n,
  input  logic [`SMC_DATA_W-1:0]  mem_rdata
);

  import smc_pkg::*;

  smc_state_t             current_state;
  logic                   load;
  logic                   le_enable;
  logic                   ws_enable;
  logic                   cste_enable;
  logic                   latch_data;
  logic                   smc_done;
  logic                   req_write_q;
  logic [1:0]             csle_count;
  logic [`SMC_WS_W-1:0]   ws_count;
  logic [1:0]             cste_count;

  assign idle = (current_state == IDLE); // Rises with done

  //--------------------------------------------------
  // Sub-blocks
  //--------------------------------------------------
  smc_state smc_state_inst (.*);

  smc_timing_counters smc_timing_counters_inst (.*);

  smc_mem_pins smc_mem_pins_inst (.*);

endmodule

// ==== verification/smc_clk_gen.sv ====
// Testbench clock source with a 10 ns period
`timescale 1ns/1ps

module smc_clk_gen
(
  output logic sys_clk27 // Free-running clock
);

  initial
  begin
    sys_clk27 = 1'b0;
    forever
      #5 sys_clk27 = ~sys_clk27; // Half period
  end

endmodule

// ==== verification/sram_model.sv ====
// Asynchronous 256-word SRAM model with level-sensitive write and gated read
`timescale 1ns/1ps
`include "smc_defs.svh"

module sram_model
(
  input  logic                    mem_cs_n,
  input  logic                    mem_oe_n,
  input  logic                    mem_we_n,
  input  logic [`SMC_ADDR_W-1:0]  mem_addr,  // Low byte decoded only
  input  logic [`SMC_DATA_W-1:0]  mem_wdata,
  output logic [`SMC_DATA_W-1:0]  mem_rdata
);

  logic [`SMC_DATA_W-1:0] cells [0:255]; // Storage array
  int                     a;

  initial
  begin
    for (a = 0; a < 256; a++)
      cells[a] = {8'(a) ^ 8'h3c, 8'(a * 7) + 8'h11}; // Power-up pattern
  end

  // Write follows the strobe while chip select is low
  always @(mem_cs_n or mem_we_n or mem_addr or mem_wdata)
  begin
    if (!mem_cs_n && !mem_we_n)
      cells[mem_addr[7:0]] = mem_wdata;
  end

  assign mem_rdata = (!mem_cs_n && !mem_oe_n) ? cells[mem_addr[7:0]] : '0; // Bus idles at zero

endmodule

// ==== verification/smc_lite_tb.sv ====
// Testbench for smc_lite with LFSR stimulus, shadow memory, assertions and timeouts
`timescale 1ns/1ps
`include "smc_defs.svh"

module smc_lite_tb;

  logic                    sys_clk27;
  logic                    n_sys_reset27;
  logic                    req;
  logic                    req_write;
  logic [`SMC_ADDR_W-1:0]  req_addr;
  logic [`SMC_DATA_W-1:0]  req_wdata;
  logic [1:0]              cfg_csle;
  logic [`SMC_WS_W-1:0]    cfg_ws;
  logic [1:0]              cfg_cste;
  logic                    done;
  logic [`SMC_DATA_W-1:0]  rdata;
  logic                    idle;
  logic [`SMC_ADDR_W-1:0]  mem_addr;
  logic [`SMC_DATA_W-1:0]  mem_wdata;
  logic                    mem_cs_n;
  logic                    mem_oe_n;
  logic                    mem_we_n;
  logic [`SMC_DATA_W-1:0]  mem_rdata;

  logic [31:0]             lfsr_state;     // Stimulus generator state
  logic [`SMC_DATA_W-1:0]  shadow [0:255]; // Expected memory contents
  int                      cs_low;         // Strobe tallies for one access
  int                      cs_first;
  int                      cs_last;
  int                      oe_low;
  int                      we_low;

  smc_clk_gen smc_clk_gen_inst (.sys_clk27(sys_clk27));
  sram_model sram_model_inst (.*);
  smc_lite smc_lite_inst (.*);

  //--------------------------------------------------
  // Helpers
  //--------------------------------------------------
  // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    int          b;
    bits = '0;
    for (b = 0; b < n; b++)
    begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual)
    else stop_on_error($sformatf("FAILED %s expected %0h actual %0h", test, expected, actual));
  endtask

  // Falling-edge sample, strobe rules checked every cycle
  task automatic sample_cycle(input int cycle);
    @(negedge sys_clk27);
    assert (mem_oe_n || mem_we_n)
    else stop_on_error("read and write strobes were low at the same time");
    assert (!mem_cs_n || (mem_oe_n && mem_we_n))
    else stop_on_error("a read or write strobe was low outside chip select");
    if (!mem_cs_n)
    begin
      if (cs_first < 0)
        cs_first = cycle; // Start of the chip select run
      cs_last = cycle;
      cs_low++;
    end
    if (!mem_oe_n)
      oe_low++;
    if (!mem_we_n)
      we_low++;
  endtask

  //--------------------------------------------------
  // One access, optionally with a strobe while busy
  //--------------------------------------------------
  task automatic run_access(input logic write, input logic [7:0] addr, input logic [1:0] csle,
                            input logic [`SMC_WS_W-1:0] ws, input logic [1:0] cste,
                            input logic poke);
    int                      cycle;
    int                      expect_edges;
    int                      poke_at;
    logic [`SMC_DATA_W-1:0]  wdata;
    wdata = 16'(take_bits(16));
    expect_edges = csle + ws + cste + 2; // Accept edge to done
    poke_at = int'(take_bits(4)) % expect_edges;
    cs_low = 0;
    cs_first = -1;
    cs_last = -1;
    oe_low = 0;
    we_low = 0;
    req = 1'b1;
    req_write = write;
    req_addr = {8'h00, addr};
    req_wdata = wdata;
    cfg_csle = csle;
    cfg_ws = ws;
    cfg_cste = cste;
    cycle = 0;
    sample_cycle(cycle); // STORE cycle
    while (!done)
    begin
      req = poke && (cycle == poke_at);
      if (req)
      begin
        req_write = !write;       // Junk that must be ignored
        req_addr = 16'(take_bits(8));
        req_wdata = ~wdata;
        cfg_csle = ~csle;
        cfg_ws = ws + 8'd5;
      end
      cycle++;
      assert (cycle <= expect_edges + 20)
      else stop_on_error("timed out waiting for done");
      sample_cycle(cycle);
      if (!mem_cs_n)
      begin
        // Address and data held from the accepted request
        check_value("memory address", {8'h00, addr}, mem_addr);
        check_value("memory write data", wdata, mem_wdata);
      end
    end
    req = 1'b0; // Next edge is idle
    check_value("done latency", expect_edges, cycle);
    check_value("idle with done", 1, idle);
    if (write)
      shadow[addr] = wdata;
    else
      check_value("read data", shadow[addr], rdata);
    check_value("chip select cycles", expect_edges - 1, cs_low);
    check_value("chip select run", cs_low, cs_last - cs_first + 1);
    check_value("strobe cycles", ws + 1, write ? we_low : oe_low);
    check_value("wrong direction strobe", 0, write ? oe_low : we_low);
    repeat (3)
    begin
      cycle++;
      sample_cycle(cycle); // No second done, no hidden access
      check_value("done after access", 0, done);
      check_value("idle after access", 1, idle);
      check_value("chip select after access", 1, mem_cs_n);
    end
  endtask

  //--------------------------------------------------
  // Main sequence
  //--------------------------------------------------
  initial
  begin
    int                    i;
    int                    a;
    logic                  write;
    logic                  have_write;
    logic [7:0]            addr;
    logic [7:0]            last_addr;
    logic [1:0]            csle;
    logic [`SMC_WS_W-1:0]  ws;
    logic [1:0]            cste;
    lfsr_state = 32'hc230_9d74;
    n_sys_reset27 = 1'b0;
    req = 1'b0;
    req_write = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    cfg_csle = 2'd0;
    cfg_ws = '0;
    cfg_cste = 2'd0;
    have_write = 1'b0;
    last_addr = 8'h00;
    for (a = 0; a < 256; a++)
      shadow[a] = {8'(a) ^ 8'h3c, 8'(a * 7) + 8'h11}; // Power-up pattern of the SRAM
    repeat (3) @(posedge sys_clk27);
    @(negedge sys_clk27);
    n_sys_reset27 = 1'b1;
    repeat (4) // Quiet state until the first request
    begin
      sample_cycle(0);
      check_value("reset idle", 1, idle);
      check_value("reset done", 0, done);
      check_value("reset strobes", 3'b111, {mem_cs_n, mem_oe_n, mem_we_n});
      check_value("reset read data", 0, rdata);
    end
    for (i = 0; i < 60; i++)
    begin
      write = 1'(take_bits(1));
      addr = 8'(take_bits(8));
      if (!write && have_write && take_bits(1) != 0)
        addr = last_addr; // Read back a fresh write
      csle = 2'(take_bits(2));
      ws = 8'(take_bits(3));
      cste = 2'(take_bits(2));
      if (i < 4)
      begin
        write = 1'b0; // Corner edge counts on reads first
        csle = i[0] ? 2'd3 : 2'd0;
        cste = i[1] ? 2'd3 : 2'd0;
      end
      run_access(write, addr, csle, ws, cste, (i % 3) == 2);
      if (write)
      begin
        have_write = 1'b1;
        last_addr = addr;
      end
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+logic
logic/smc_pkg.sv
logic/smc_state.sv
logic/smc_timing_counters.sv
logic/smc_mem_pins.sv
logic/smc_lite.sv
verification/smc_clk_gen.sv
verification/sram_model.sv
verification/smc_lite_tb.sv

// ==== Makefile ====
# Verilator build and run of the smc_lite testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module smc_lite_tb -o smc_lite_tb
	./obj_dir/smc_lite_tb

clean:
	rm -rf obj_dir
